// File: build.f
+incdir+verification
source/fsqrt_pkg.sv
source/fsqrt_lane_split.sv
source/fsqrt_pe.sv
source/fsqrt_lane_merge.sv
source/fsqrt_unit.sv
verification/fsqrt_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile with Verilator, run, and pass only if the testbench reports a pass
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module fsqrt_tb -f build.f -o fsqrt_sim \
    && out="$(./obj_dir/fsqrt_sim)" \
    && echo "$out" \
    && echo "$out" | grep -qx "TEST PASS" \
    || { echo "Simulation did not pass"; exit 1; }

// File: source/fsqrt_lane_merge.sv
`timescale 1ns/1ps

module fsqrt_lane_merge #(
    parameter int num_lanes = 4,
    parameter int num_pes   = 2,
    parameter int tag_width = 4,
    parameter int latency   = 4
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                pe_valid,
    input  logic                                pe_first,
    input  logic                                pe_last,
    input  logic [num_pes-1:0]                  pe_mask,
    input  logic [tag_width-1:0]                pe_tag,
    input  logic [num_pes-1:0][31:0]            pe_result,
    input  fsqrt_pkg::fflags_t [num_pes-1:0]    pe_flags,
    output logic                                pe_enable,
    output logic                                valid_out,
    input  logic                                ready_out,
    output logic [num_lanes-1:0][31:0]          result,
    output fsqrt_pkg::fflags_t                  fflags,
    output logic [tag_width-1:0]                tag_out
);
    import fsqrt_pkg::*;

    logic [latency-1:0]                 dl_valid;
    logic [latency-1:0]                 dl_first;
    logic [latency-1:0]                 dl_last;
    logic [num_pes-1:0]                 dl_mask [latency];
    logic [tag_width-1:0]               dl_tag  [latency];
    logic                               d_valid;
    logic                               d_first;
    logic                               d_last;
    logic                               d_done;
    logic [num_pes-1:0][31:0]           cur_result;
    fflags_t                            cur_flags;
    fflags_t                            run_flags;
    fflags_t                            merged_flags;
    logic [num_lanes-1:0][31:0]         acc;
    logic [num_lanes+num_pes-1:0][31:0] joined;
    logic [num_lanes-1:0][31:0]         shifted;

    // The sideband delay line has the same depth as the PE pipeline
    always_ff @(posedge clk) begin
        if (reset) begin
            dl_valid <= '0;
            dl_first <= '0;
            dl_last  <= '0;
        end else if (pe_enable) begin
            dl_valid <= {dl_valid[latency-2:0], pe_valid};
            dl_first <= {dl_first[latency-2:0], pe_first};
            dl_last  <= {dl_last[latency-2:0], pe_last};
        end
    end

    always_ff @(posedge clk) begin
        if (pe_enable) begin
            dl_mask[0] <= pe_mask;
            dl_tag[0]  <= pe_tag;
            for (int i = 1; i < latency; i++) begin
                dl_mask[i] <= dl_mask[i-1];
                dl_tag[i]  <= dl_tag[i-1];
            end
        end
    end

    assign d_valid = dl_valid[latency-1];
    assign d_first = dl_first[latency-1];
    assign d_last  = dl_last[latency-1];
    assign d_done  = d_valid & d_last;

    // Masked lanes read as zero and add nothing to the flags
    always_comb begin
        cur_flags = '0;
        for (int p = 0; p < num_pes; p++) begin
            if (dl_mask[latency-1][p]) begin
                cur_result[p] = pe_result[p];
                cur_flags     = cur_flags | pe_flags[p];
            end else begin
                cur_result[p] = '0;
            end
        end
        merged_flags = cur_flags;
        if (!d_first) begin
            merged_flags = merged_flags | run_flags;
        end
    end

    // Batches come back in order, so shifting each one in from the top
    // leaves batch 0 in the lowest lanes once the last batch is in
    assign joined  = {cur_result, acc};
    assign shifted = joined[num_lanes+num_pes-1:num_pes];

    always_ff @(posedge clk) begin
        if (pe_enable && d_valid) begin
            acc       <= shifted;
            run_flags <= merged_flags;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_out <= 1'b0;
        end else if (pe_enable && d_done) begin
            valid_out <= 1'b1;
        end else if (ready_out) begin
            valid_out <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (pe_enable && d_done) begin
            result  <= shifted;
            fflags  <= merged_flags;
            tag_out <= dl_tag[latency-1];
        end
    end

    // Freeze everything when a finished result would overwrite one still waiting
    assign pe_enable = ~(valid_out & ~ready_out & d_done);

endmodule

// File: source/fsqrt_lane_split.sv
`timescale 1ns/1ps

module fsqrt_lane_split #(
    parameter int num_lanes = 4,
    parameter int num_pes   = 2,
    parameter int tag_width = 4
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             valid_in,
    output logic                             ready_in,
    input  logic [num_lanes-1:0]             mask_in,
    input  logic [tag_width-1:0]             tag_in,
    input  logic [fsqrt_pkg::frm_bits-1:0]   frm,
    input  logic [num_lanes-1:0][31:0]       dataa,
    input  logic                             pe_enable,
    output logic                             pe_valid,
    output logic                             pe_first,
    output logic                             pe_last,
    output logic [num_pes-1:0]               pe_mask,
    output logic [tag_width-1:0]             pe_tag,
    output logic [fsqrt_pkg::frm_bits-1:0]   pe_frm,
    output logic [num_pes-1:0][31:0]         pe_data
);
    import fsqrt_pkg::*;

    localparam int passes   = num_lanes / num_pes;
    localparam int cnt_bits = (passes > 1) ? $clog2(passes) : 1;
    localparam logic [cnt_bits-1:0] last_batch = cnt_bits'(passes - 1);

    logic [num_lanes-1:0][31:0] req_data;
    logic [num_lanes-1:0]       req_mask;
    logic [cnt_bits-1:0]        batch;
    logic                       accept;

    // A new request may load while the last batch of the previous one is issued
    assign ready_in = pe_enable & (~pe_valid | pe_last);
    assign accept   = valid_in & ready_in;

    assign pe_first = (batch == '0);
    assign pe_last  = (batch == last_batch);

    // The lowest lanes of the request register always form the current batch
    assign pe_data = req_data[num_pes-1:0];
    assign pe_mask = req_mask[num_pes-1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            pe_valid <= 1'b0;
            batch    <= '0;
        end else if (pe_enable) begin
            if (accept) begin
                pe_valid <= 1'b1;
                batch    <= '0;
            end else if (pe_valid && !pe_last) begin
                batch <= batch + cnt_bits'(1);
            end else begin
                pe_valid <= 1'b0;
            end
        end
    end

    // Each enabled cycle drops the batch just issued and brings the next one down
    always_ff @(posedge clk) begin
        if (accept) begin
            req_data <= dataa;
            req_mask <= mask_in;
            pe_tag   <= tag_in;
            pe_frm   <= frm;
        end else if (pe_enable) begin
            req_data <= req_data >> (num_pes * 32);
            req_mask <= req_mask >> num_pes;
        end
    end

endmodule

// File: source/fsqrt_pe.sv
`timescale 1ns/1ps

module fsqrt_pe #(
    parameter int latency = 4
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           enable,
    input  logic [31:0]                    operand,
    input  logic [fsqrt_pkg::frm_bits-1:0] frm,
    output logic [31:0]                    result,
    output fsqrt_pkg::fflags_t             flags
);
    import fsqrt_pkg::*;

    // 24 significand bits, a round bit and one more below it
    localparam int root_bits = 26;
    localparam int rad_bits  = 2 * root_bits;
    localparam int rem_bits  = root_bits + 2;
    // Register 0 holds the decode, the iterations run between the registers
    localparam int groups    = latency - 1;
    localparam int iter_per  = (root_bits + groups - 1) / groups;

    typedef struct packed {
        logic                     special;
        logic [31:0]              spec_res;
        logic                     spec_nv;
        logic [frm_bits-1:0]      frm;
        logic [fp32_exp_bits-1:0] exp_r;
        logic [rad_bits-1:0]      rad;
        logic [root_bits-1:0]     q;
        logic [rem_bits-1:0]      rem;
    } stage_t;

    function automatic stage_t decode(logic [31:0] x, logic [frm_bits-1:0] rm);
        logic                     sign;
        logic [fp32_exp_bits-1:0] expo;
        logic [fp32_man_bits-1:0] man;
        logic [fp32_exp_bits:0]   exp_sum;
        stage_t                   s;
        sign = x[31];
        expo = x[fp32_man_bits +: fp32_exp_bits];
        man  = x[fp32_man_bits-1:0];
        s    = '0;
        // Unused encodings behave as nearest-even
        s.frm = (rm > rm_rup) ? rm_rne : rm;
        // (exp + bias) / 2 is the halved unbiased exponent rounded toward minus infinity
        exp_sum = {1'b0, expo} + 9'd127;
        s.exp_r = exp_sum[fp32_exp_bits:1];
        // An odd unbiased exponent (even biased one) shifts one more bit into the radicand
        s.rad = expo[0] ? {2'b01, man, 27'b0} : {1'b1, man, 28'b0};
        s.special = 1'b1;
        if (&expo && man != '0) begin
            s.spec_res = fp32_qnan;
            s.spec_nv  = ~man[fp32_man_bits-1];
        end else if (expo == '0) begin
            // Subnormals are flushed, so they share the signed zero result
            s.spec_res = {sign, 31'b0};
        end else if (sign) begin
            s.spec_res = fp32_qnan;
            s.spec_nv  = 1'b1;
        end else if (&expo) begin
            s.spec_res = x;
        end else begin
            s.special = 1'b0;
        end
        return s;
    endfunction

    // One restoring step, two radicand bits in and one root bit out
    function automatic stage_t root_step(stage_t s);
        logic [rem_bits+1:0] r_try;
        logic [rem_bits+1:0] trial;
        logic [rem_bits+1:0] diff;
        stage_t              n;
        n     = s;
        r_try = {s.rem, s.rad[rad_bits-1 -: 2]};
        trial = {2'b00, s.q, 2'b01};
        diff  = r_try - trial;
        n.rad = {s.rad[rad_bits-3:0], 2'b00};
        if (r_try >= trial) begin
            n.rem = diff[rem_bits-1:0];
            n.q   = {s.q[root_bits-2:0], 1'b1};
        end else begin
            n.rem = r_try[rem_bits-1:0];
            n.q   = {s.q[root_bits-2:0], 1'b0};
        end
        return n;
    endfunction

    stage_t      st  [groups];
    stage_t      nxt [groups];
    logic [31:0] fin_res;
    fflags_t     fin_flags;

    always_ff @(posedge clk) begin
        if (enable) begin
            st[0] <= decode(operand, frm);
            for (int g = 1; g < groups; g++) begin
                st[g] <= nxt[g-1];
            end
        end
    end

    always_comb begin
        stage_t s;
        for (int g = 0; g < groups; g++) begin
            s = st[g];
            for (int i = 0; i < root_bits; i++) begin
                if (i / iter_per == g) begin
                    s = root_step(s);
                end
            end
            nxt[g] = s;
        end
    end

    always_comb begin
        stage_t      s;
        logic        rb;
        logic        sticky;
        logic        inc;
        logic [30:0] body;
        s      = nxt[groups-1];
        rb     = s.q[1];
        sticky = s.q[0] | (|s.rem);
        // The root is never negative, so round-down truncates like round-toward-zero
        case (s.frm)
            rm_rtz, rm_rdn: inc = 1'b0;
            rm_rup:         inc = rb | sticky;
            default:        inc = rb & (sticky | s.q[2]);
        endcase
        // A carry out of the mantissa lands in the exponent
        body      = {s.exp_r, s.q[24:2]} + {30'b0, inc};
        fin_flags = '0;
        if (s.special) begin
            fin_res      = s.spec_res;
            fin_flags.nv = s.spec_nv;
        end else begin
            fin_res      = {1'b0, body};
            fin_flags.nx = rb | sticky;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            flags <= '0;
        end else if (enable) begin
            flags <= fin_flags;
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            result <= fin_res;
        end
    end

endmodule

// File: source/fsqrt_pkg.sv
package fsqrt_pkg;

    // Rounding mode field as carried with each request
    localparam int frm_bits = 3;

    localparam logic [frm_bits-1:0] rm_rne = 3'd0;
    localparam logic [frm_bits-1:0] rm_rtz = 3'd1;
    localparam logic [frm_bits-1:0] rm_rdn = 3'd2;
    localparam logic [frm_bits-1:0] rm_rup = 3'd3;

    // Single precision field widths
    localparam int fp32_exp_bits = 8;
    localparam int fp32_man_bits = 23;

    // Canonical quiet NaN returned for every invalid or NaN input
    localparam logic [31:0] fp32_qnan = 32'h7fc0_0000;

    // The exception flags run from invalid in the top bit down to inexact in bit 0
    typedef struct packed {
        logic nv;
        logic dz;
        logic of;
        logic uf;
        logic nx;
    } fflags_t;

endpackage

// File: source/fsqrt_unit.sv
`timescale 1ns/1ps

module fsqrt_unit #(
    parameter int num_lanes = 4,
    parameter int num_pes   = 2,
    parameter int tag_width = 4,
    parameter int latency   = 4
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           valid_in,
    output logic                           ready_in,
    input  logic [num_lanes-1:0]           mask_in,
    input  logic [tag_width-1:0]           tag_in,
    input  logic [fsqrt_pkg::frm_bits-1:0] frm,
    input  logic [num_lanes-1:0][31:0]     dataa,
    output logic                           valid_out,
    input  logic                           ready_out,
    output logic [num_lanes-1:0][31:0]     result,
    output fsqrt_pkg::fflags_t             fflags,
    output logic [tag_width-1:0]           tag_out
);
    import fsqrt_pkg::*;

    logic                     pe_enable;
    logic                     pe_valid;
    logic                     pe_first;
    logic                     pe_last;
    logic [num_pes-1:0]       pe_mask;
    logic [tag_width-1:0]     pe_tag;
    logic [frm_bits-1:0]      pe_frm;
    logic [num_pes-1:0][31:0] pe_data;
    logic [num_pes-1:0][31:0] pe_result;
    fflags_t [num_pes-1:0]    pe_flags;

    fsqrt_lane_split #(
        .num_lanes (num_lanes),
        .num_pes   (num_pes),
        .tag_width (tag_width)
    ) u_split (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (valid_in),
        .ready_in  (ready_in),
        .mask_in   (mask_in),
        .tag_in    (tag_in),
        .frm       (frm),
        .dataa     (dataa),
        .pe_enable (pe_enable),
        .pe_valid  (pe_valid),
        .pe_first  (pe_first),
        .pe_last   (pe_last),
        .pe_mask   (pe_mask),
        .pe_tag    (pe_tag),
        .pe_frm    (pe_frm),
        .pe_data   (pe_data)
    );

    // All PEs share the rounding mode of the batch in flight
    for (genvar i = 0; i < num_pes; i++) begin : g_pe
        fsqrt_pe #(
            .latency (latency)
        ) u_pe (
            .clk     (clk),
            .reset   (reset),
            .enable  (pe_enable),
            .operand (pe_data[i]),
            .frm     (pe_frm),
            .result  (pe_result[i]),
            .flags   (pe_flags[i])
        );
    end

    fsqrt_lane_merge #(
        .num_lanes (num_lanes),
        .num_pes   (num_pes),
        .tag_width (tag_width),
        .latency   (latency)
    ) u_merge (
        .clk       (clk),
        .reset     (reset),
        .pe_valid  (pe_valid),
        .pe_first  (pe_first),
        .pe_last   (pe_last),
        .pe_mask   (pe_mask),
        .pe_tag    (pe_tag),
        .pe_result (pe_result),
        .pe_flags  (pe_flags),
        .pe_enable (pe_enable),
        .valid_out (valid_out),
        .ready_out (ready_out),
        .result    (result),
        .fflags    (fflags),
        .tag_out   (tag_out)
    );

endmodule

// File: verification/fsqrt_model.svh
// Largest q with q * q <= v
function automatic logic [63:0] int_sqrt(logic [63:0] v);
    logic [63:0] q;
    logic [63:0] cand;
    q = '0;
    for (int b = 31; b >= 0; b--) begin
        cand = q | (64'd1 << b);
        if (cand * cand <= v) begin
            q = cand;
        end
    end
    return q;
endfunction

// Correctly rounded square root of one lane with its exception flags
function automatic void fp32_sqrt_ref(input logic [31:0] x, input logic [frm_bits-1:0] rm,
                                      output logic [31:0] res, output fflags_t fl);
    logic        sign;
    logic [7:0]  expo;
    logic [22:0] man;
    int          e_unb;
    int          e_half;
    logic [63:0] rad;
    logic [63:0] q2;
    logic [23:0] q;
    logic        rb;
    logic        sticky;
    logic        inc;
    logic [30:0] body;
    sign = x[31];
    expo = x[30:23];
    man  = x[22:0];
    fl   = '0;
    res  = '0;
    if (expo == 8'hff && man != '0) begin
        // Any NaN gives the canonical one, only a signalling NaN is invalid
        res   = fp32_qnan;
        fl.nv = ~man[22];
    end else if (expo == 8'h00) begin
        res = {sign, 31'b0};
    end else if (sign) begin
        res   = fp32_qnan;
        fl.nv = 1'b1;
    end else if (expo == 8'hff) begin
        res = x;
    end else begin
        e_unb  = int'(expo) - 127;
        e_half = e_unb >>> 1;
        // An odd exponent moves one factor of two under the root.
        // Two extra radicand bits give the root one bit below the last place
        rad    = {40'b0, 1'b1, man} << (((e_unb & 1) != 0) ? 26 : 25);
        q2     = int_sqrt(rad);
        q      = q2[24:1];
        rb     = q2[0];
        sticky = (q2 * q2 != rad);
        case (rm)
            rm_rtz, rm_rdn: inc = 1'b0;
            rm_rup:         inc = rb | sticky;
            default:        inc = rb & (sticky | q[0]);
        endcase
        body  = {8'(e_half + 127), q[22:0]} + {30'b0, inc};
        res   = {1'b0, body};
        fl.nx = rb | sticky;
    end
endfunction

// File: verification/fsqrt_tb.sv
`timescale 1ns/1ps

module fsqrt_tb;
    import fsqrt_pkg::*;

    localparam int num_lanes = 4;
    localparam int num_pes   = 2;
    localparam int tag_width = 4;
    localparam int latency   = 4;
    localparam int passes    = num_lanes / num_pes;
    localparam int max_wait  = 1000;

    `include "fsqrt_model.svh"

    logic                       clk;
    logic                       reset;
    logic                       valid_in;
    logic                       ready_in;
    logic [num_lanes-1:0]       mask_in;
    logic [tag_width-1:0]       tag_in;
    logic [frm_bits-1:0]        frm;
    logic [num_lanes-1:0][31:0] dataa;
    logic                       valid_out;
    logic                       ready_out = 1'b1;
    logic [num_lanes-1:0][31:0] result;
    fflags_t                    fflags;
    logic [tag_width-1:0]       tag_out;

    logic [num_lanes-1:0][31:0] exp_result [$];
    fflags_t                    exp_flags  [$];
    logic [tag_width-1:0]       exp_tag    [$];
    string                      exp_test   [$];
    string                      test_name;
    logic                       backpressure;
    logic [tag_width-1:0]       next_tag;
    int                         value_errors = 0;
    int                         proto_errors = 0;
    int                         seq_errors;
    logic                       hold_pending = 1'b0;
    logic [num_lanes-1:0][31:0] held_result;
    fflags_t                    held_flags;
    logic [tag_width-1:0]       held_tag;

    fsqrt_unit #(
        .num_lanes (num_lanes),
        .num_pes   (num_pes),
        .tag_width (tag_width),
        .latency   (latency)
    ) u_fsqrt_unit (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (valid_in),
        .ready_in  (ready_in),
        .mask_in   (mask_in),
        .tag_in    (tag_in),
        .frm       (frm),
        .dataa     (dataa),
        .valid_out (valid_out),
        .ready_out (ready_out),
        .result    (result),
        .fflags    (fflags),
        .tag_out   (tag_out)
    );

    always #5 clk = ~clk;

    // Kinds 0 and 1 are finite positives, the rest are the special classes
    function automatic logic [31:0] random_operand(int kind);
        logic        sign;
        logic [7:0]  expo;
        logic [22:0] man;
        logic [23:0] sq;
        int          k;
        int          j;
        sign = 1'($urandom);
        expo = 8'(1 + $urandom % 254);
        man  = 23'($urandom);
        case (kind)
            0: return {1'b0, expo, man};
            1: begin
                // A 12 bit integer squared, scaled by an even power of two
                k  = 2048 + int'($urandom % 2048);
                j  = int'($urandom % 41) - 20;
                sq = 24'(k * k);
                if (sq[23]) begin
                    return {1'b0, 8'(150 + 2 * j), sq[22:0]};
                end
                return {1'b0, 8'(149 + 2 * j), sq[21:0], 1'b0};
            end
            2: return {sign, 31'b0};
            3: return {1'b1, expo, man};
            4: return {sign, 8'hff, 23'b0};
            5: return {sign, 8'hff, 1'b1, man[21:0]};
            6: return {sign, 8'hff, 1'b0, man[21:1], 1'b1};
            default: return {sign, 8'h00, man[22:1], 1'b1};
        endcase
    endfunction

    // Every fifth request uses one of the unused encodings
    function automatic logic [frm_bits-1:0] pick_mode(int i);
        if (i % 5 == 4) begin
            return frm_bits'(4 + $urandom % 4);
        end
        return frm_bits'(i % 5);
    endfunction

    task automatic finish_run();
        $display("Errors: %0d value, %0d protocol, %0d sequence",
                 value_errors, proto_errors, seq_errors);
        if (value_errors == 0 && proto_errors == 0 && seq_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    endtask

    task automatic send_request(int kinds, logic [num_lanes-1:0] mask, logic [frm_bits-1:0] rm);
        logic [num_lanes-1:0][31:0] ops;
        int                         waited;
        for (int l = 0; l < num_lanes; l++) begin
            ops[l] = random_operand(int'($urandom % kinds));
        end
        valid_in <= 1'b1;
        mask_in  <= mask;
        tag_in   <= next_tag;
        frm      <= rm;
        dataa    <= ops;
        next_tag = next_tag + 1'b1;
        waited   = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (!ready_in && waited < max_wait);
        if (!ready_in) begin
            $display("Timeout: request with tag %0d was never accepted", tag_in);
            seq_errors++;
            finish_run();
        end
    endtask

    task automatic idle_cycles(int n);
        valid_in <= 1'b0;
        repeat (n) @(posedge clk);
    endtask

    task automatic drain_results();
        int waited;
        valid_in <= 1'b0;
        waited = 0;
        while (exp_result.size() != 0 && waited < max_wait) begin
            @(posedge clk);
            waited++;
        end
        if (exp_result.size() != 0) begin
            $display("Timeout: %0d results never came back", exp_result.size());
            seq_errors++;
            finish_run();
        end
    endtask

    // Records accepted requests, checks returned results and drives ready_out
    always @(posedge clk) begin
        logic [num_lanes-1:0][31:0] lanes;
        fflags_t                    acc_flags;
        logic [31:0]                lane_res;
        fflags_t                    lane_fl;
        fflags_t                    want_flags;
        logic [tag_width-1:0]       want_tag;
        string                      name;
        if (!reset && valid_in && ready_in) begin
            lanes     = '0;
            acc_flags = '0;
            for (int l = 0; l < num_lanes; l++) begin
                if (mask_in[l]) begin
                    fp32_sqrt_ref(dataa[l], frm, lane_res, lane_fl);
                    lanes[l]  = lane_res;
                    acc_flags = acc_flags | lane_fl;
                end
            end
            exp_result.push_back(lanes);
            exp_flags.push_back(acc_flags);
            exp_tag.push_back(tag_in);
            exp_test.push_back(test_name);
        end
        if (!reset && valid_out && ready_out) begin
            if (exp_result.size() == 0) begin
                $display("Unexpected output with tag %0d and no request outstanding", tag_out);
                proto_errors++;
            end else begin
                lanes      = exp_result.pop_front();
                want_flags = exp_flags.pop_front();
                want_tag   = exp_tag.pop_front();
                name       = exp_test.pop_front();
                for (int l = 0; l < num_lanes; l++) begin
                    if (result[l] !== lanes[l]) begin
                        $display("[ERROR] %s: lane %0d expected %h actual %h",
                                 name, l, lanes[l], result[l]);
                        value_errors++;
                    end
                end
                if (fflags !== want_flags) begin
                    $display("[ERROR] %s: fflags expected %b actual %b", name, want_flags, fflags);
                    value_errors++;
                end
                if (tag_out !== want_tag) begin
                    $display("[ERROR] %s: tag expected %0d actual %0d", name, want_tag, tag_out);
                    value_errors++;
                end
            end
        end
        if (hold_pending) begin
            if (!valid_out || result != held_result || fflags != held_flags ||
                tag_out != held_tag) begin
                $display("Output changed or was dropped while ready_out was low");
                proto_errors++;
            end
        end
        hold_pending = !reset && valid_out && !ready_out;
        held_result  = result;
        held_flags   = fflags;
        held_tag     = tag_out;
        if (backpressure) begin
            ready_out <= ($urandom % 3) != 0;
        end else begin
            ready_out <= 1'b1;
        end
    end

    initial begin
        int waited;
        void'($urandom(45));
        clk          = 1'b0;
        reset        = 1'b1;
        valid_in     = 1'b0;
        mask_in      = '0;
        tag_in       = '0;
        frm          = rm_rne;
        dataa        = '0;
        backpressure = 1'b0;
        next_tag     = '0;
        seq_errors   = 0;
        test_name    = "reset";
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        if (ready_in !== 1'b1) begin
            $display("[ERROR] reset: ready_in expected 1 actual %b", ready_in);
            seq_errors++;
        end
        if (valid_out !== 1'b0) begin
            $display("[ERROR] reset: valid_out expected 0 actual %b", valid_out);
            seq_errors++;
        end

        // valid_out rises passes + latency edges after acceptance and is seen one edge later
        test_name = "latency";
        send_request(2, '1, rm_rne);
        valid_in <= 1'b0;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (!valid_out && waited < max_wait);
        if (!valid_out) begin
            $display("Timeout: valid_out never rose after the first request");
            seq_errors++;
            finish_run();
        end else if (waited != passes + latency + 1) begin
            $display("[ERROR] latency: expected %0d actual %0d", passes + latency + 1, waited);
            seq_errors++;
        end
        drain_results();

        test_name = "rounding";
        for (int i = 0; i < 400; i++) begin
            send_request(2, '1, pick_mode(i));
        end
        drain_results();

        test_name = "special";
        for (int i = 0; i < 150; i++) begin
            send_request(8, '1, pick_mode(i));
        end
        drain_results();

        test_name = "mask";
        for (int i = 0; i < 150; i++) begin
            send_request(8, num_lanes'($urandom), pick_mode(i));
        end
        drain_results();

        test_name    = "backpressure";
        backpressure = 1'b1;
        for (int i = 0; i < 300; i++) begin
            if ($urandom % 4 == 0) begin
                idle_cycles(1 + int'($urandom % 3));
            end
            send_request(8, num_lanes'($urandom), pick_mode(i));
        end
        drain_results();
        finish_run();
    end

endmodule
